//--- verilog/rv_core_pkg.sv
// Core vector typedefs, opcode/ALU/branch/state enums, select codes, decode and write-back structs
package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // Branch conditions straight from funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    DECODE    = 3'd1,
    EXECUTE   = 3'd2,
    WRITEBACK = 3'd3,
    HALTED    = 3'd4
  } exec_state_t;

  // Operand and write-back select codes
  localparam logic       A_RS1    = 1'b0;
  localparam logic       A_PC     = 1'b1;
  localparam logic       B_RS2    = 1'b0;
  localparam logic       B_IMM    = 1'b1;
  localparam logic [1:0] WSEL_ALU = 2'd0;
  localparam logic [1:0] WSEL_PC4 = 2'd1;
  localparam logic [1:0] WSEL_IMM = 2'd2;

  // jal x0, 0 is the halt idiom
  localparam word_t HALT_WORD = 32'h0000_006f;

  typedef struct packed {
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm;
    alu_op_t    alu_op;
    logic       alu_a_sel;
    logic       alu_b_sel;
    logic [1:0] w_sel;
    logic       wen;
    logic       branch;
    logic       jal;
    logic       jalr;
    branch_t    branch_type;
    logic       illegal;
    logic       halt;
  } decode_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

endpackage

//--- verilog/control_unit.sv
// Combinational RV32I decoder producing the decode struct
`timescale 1ns/1ps

module control_unit (
  input  rv_core_pkg::word_t   instr_i,
  output rv_core_pkg::decode_t dec_o
);

  // funct3 codes for the integer ALU group
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  rv_core_pkg::opcode_t opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  rv_core_pkg::word_t   imm_i;
  rv_core_pkg::word_t   imm_s;
  rv_core_pkg::word_t   imm_b;
  rv_core_pkg::word_t   imm_u;
  rv_core_pkg::word_t   imm_j;
  rv_core_pkg::alu_op_t group_op;
  logic                 regreg_bad;

  assign opcode = rv_core_pkg::opcode_t'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign-extended immediates for each format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // Only ADD/SUB and SRL/SRA accept the alternate funct7
  assign regreg_bad = (funct7 != F7_BASE) &&
                      !((funct7 == F7_ALT) && ((funct3 == F3_ADD) || (funct3 == F3_SR)));

  // ALU operation shared by IMMED and REGREG
  always_comb begin
    case (funct3)
      F3_ADD: begin
        if ((opcode == rv_core_pkg::REGREG) && instr_i[30])
          group_op = rv_core_pkg::ALU_SUB;
        else
          group_op = rv_core_pkg::ALU_ADD;
      end
      F3_SLL:  group_op = rv_core_pkg::ALU_SLL;
      F3_SLT:  group_op = rv_core_pkg::ALU_SLT;
      F3_SLTU: group_op = rv_core_pkg::ALU_SLTU;
      F3_XOR:  group_op = rv_core_pkg::ALU_XOR;
      F3_SR:   group_op = instr_i[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      F3_OR:   group_op = rv_core_pkg::ALU_OR;
      F3_AND:  group_op = rv_core_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    dec_o.rs1         = instr_i[19:15];
    dec_o.rs2         = instr_i[24:20];
    dec_o.rd          = instr_i[11:7];
    dec_o.imm         = imm_i;
    dec_o.alu_op      = rv_core_pkg::ALU_ADD;
    dec_o.alu_a_sel   = rv_core_pkg::A_RS1;
    dec_o.alu_b_sel   = rv_core_pkg::B_RS2;
    dec_o.w_sel       = rv_core_pkg::WSEL_ALU;
    dec_o.wen         = 1'b0;
    dec_o.branch      = 1'b0;
    dec_o.jal         = 1'b0;
    dec_o.jalr        = 1'b0;
    dec_o.branch_type = rv_core_pkg::branch_t'(funct3);
    dec_o.illegal     = 1'b0;
    dec_o.halt        = (instr_i == rv_core_pkg::HALT_WORD);

    case (opcode)
      rv_core_pkg::LUI: begin
        dec_o.imm   = imm_u;
        dec_o.w_sel = rv_core_pkg::WSEL_IMM;
        dec_o.wen   = 1'b1;
      end
      rv_core_pkg::AUIPC: begin
        dec_o.imm       = imm_u;
        dec_o.alu_a_sel = rv_core_pkg::A_PC;
        dec_o.alu_b_sel = rv_core_pkg::B_IMM;
        dec_o.wen       = 1'b1;
      end
      rv_core_pkg::JAL: begin
        dec_o.imm   = imm_j;
        dec_o.jal   = 1'b1;
        dec_o.w_sel = rv_core_pkg::WSEL_PC4;
        dec_o.wen   = 1'b1;
      end
      rv_core_pkg::JALR: begin
        dec_o.jalr  = 1'b1;
        dec_o.w_sel = rv_core_pkg::WSEL_PC4;
        dec_o.wen   = 1'b1;
      end
      rv_core_pkg::BRANCH: begin
        dec_o.imm    = imm_b;
        dec_o.branch = 1'b1;
      end
      rv_core_pkg::IMMED: begin
        dec_o.alu_op    = group_op;
        dec_o.alu_b_sel = rv_core_pkg::B_IMM;
        dec_o.wen       = 1'b1;
      end
      rv_core_pkg::REGREG: begin
        dec_o.alu_op  = group_op;
        dec_o.wen     = !regreg_bad;
        dec_o.illegal = regreg_bad;
      end
      // Stores are not supported, format kept for completeness
      rv_core_pkg::STORE: begin
        dec_o.imm     = imm_s;
        dec_o.illegal = 1'b1;
      end
      default: dec_o.illegal = 1'b1;
    endcase
  end

endmodule

//--- verilog/reg_file.sv
// 32x32 register file, two combinational read ports, one write port, x0 tied to zero
`timescale 1ns/1ps

module reg_file (
  input  logic                  clk,
  input  logic                  rst_i,
  input  rv_core_pkg::reg_idx_t rs1_i,
  input  rv_core_pkg::reg_idx_t rs2_i,
  input  rv_core_pkg::reg_idx_t rd_i,
  input  logic                  we_i,
  input  rv_core_pkg::word_t    wdata_i,
  output rv_core_pkg::word_t    rdata1_o,
  output rv_core_pkg::word_t    rdata2_o
);

  rv_core_pkg::word_t regs [32];

  // Entry 0 is cleared by reset and never written
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

  // x0 must never pick up a write
  a_x0_zero: assert property (@(posedge clk) disable iff (rst_i)
    (rs1_i == '0) |-> (rdata1_o == '0));

endmodule

//--- verilog/alu.sv
// ALU with operand selection, branch compare and next-PC generation
`timescale 1ns/1ps

module alu (
  input  rv_core_pkg::decode_t dec_i,
  input  rv_core_pkg::word_t   rs1_val_i,
  input  rv_core_pkg::word_t   rs2_val_i,
  input  rv_core_pkg::word_t   pc_i,
  output rv_core_pkg::word_t   result_o,
  output rv_core_pkg::word_t   next_pc_o
);

  rv_core_pkg::word_t op_a;
  rv_core_pkg::word_t op_b;
  rv_core_pkg::word_t alu_out;
  rv_core_pkg::word_t pc_plus4;
  rv_core_pkg::word_t jalr_target;
  logic [4:0]         shamt;
  logic               taken;

  assign op_a     = (dec_i.alu_a_sel == rv_core_pkg::A_PC) ? pc_i : rs1_val_i;
  assign op_b     = (dec_i.alu_b_sel == rv_core_pkg::B_IMM) ? dec_i.imm : rs2_val_i;
  assign shamt    = op_b[4:0];
  assign pc_plus4 = pc_i + 32'd4;

  always_comb begin
    case (dec_i.alu_op)
      rv_core_pkg::ALU_ADD:  alu_out = op_a + op_b;
      rv_core_pkg::ALU_SUB:  alu_out = op_a - op_b;
      rv_core_pkg::ALU_SLL:  alu_out = op_a << shamt;
      rv_core_pkg::ALU_SRL:  alu_out = op_a >> shamt;
      rv_core_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
      rv_core_pkg::ALU_AND:  alu_out = op_a & op_b;
      rv_core_pkg::ALU_OR:   alu_out = op_a | op_b;
      rv_core_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
      rv_core_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_core_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
      default:               alu_out = '0;
    endcase
  end

  // Branch condition on the raw register values
  always_comb begin
    case (dec_i.branch_type)
      rv_core_pkg::BEQ:  taken = (rs1_val_i == rs2_val_i);
      rv_core_pkg::BNE:  taken = (rs1_val_i != rs2_val_i);
      rv_core_pkg::BLT:  taken = ($signed(rs1_val_i) < $signed(rs2_val_i));
      rv_core_pkg::BGE:  taken = ($signed(rs1_val_i) >= $signed(rs2_val_i));
      rv_core_pkg::BLTU: taken = (rs1_val_i < rs2_val_i);
      rv_core_pkg::BGEU: taken = (rs1_val_i >= rs2_val_i);
      default:           taken = 1'b0;
    endcase
  end

  always_comb begin
    case (dec_i.w_sel)
      rv_core_pkg::WSEL_PC4: result_o = pc_plus4;
      rv_core_pkg::WSEL_IMM: result_o = dec_i.imm;
      default:               result_o = alu_out;
    endcase
  end

  assign jalr_target = (rs1_val_i + dec_i.imm) & ~32'd1;

  always_comb begin
    if (dec_i.jalr)
      next_pc_o = jalr_target;
    else if (dec_i.jal || (dec_i.branch && taken))
      next_pc_o = pc_i + dec_i.imm;
    else
      next_pc_o = pc_plus4;
  end

endmodule

//--- verilog/pc_counter.sv
// Architectural program counter and retired-instruction counter
`timescale 1ns/1ps

module pc_counter #(
  parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               commit_i,
  input  rv_core_pkg::word_t next_pc_i,
  output rv_core_pkg::word_t pc_o,
  output rv_core_pkg::word_t instret_o
);

  rv_core_pkg::word_t pc_q;
  rv_core_pkg::word_t instret_q;

  // Both counters move only when an instruction retires
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q      <= RESET_PC;
      instret_q <= '0;
    end else if (commit_i) begin
      pc_q      <= next_pc_i;
      instret_q <= instret_q + 32'd1;
    end
  end

  assign pc_o      = pc_q;
  assign instret_o = instret_q;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst_i)
    (commit_i && (next_pc_i[1:0] == 2'b00)) |=> (pc_o[1:0] == 2'b00));

endmodule

//--- verilog/exec_fsm.sv
// Sequencing FSM for accept, decode, execute, write-back and halt
`timescale 1ns/1ps

module exec_fsm (
  input  logic clk,
  input  logic rst_i,
  input  logic instr_valid_i,
  input  logic halt_i,
  output logic load_ir_o,
  output logic dec_en_o,
  output logic ex_en_o,
  output logic commit_o,
  output logic busy_o,
  output logic halted_o
);

  rv_core_pkg::exec_state_t state_q;
  rv_core_pkg::exec_state_t state_d;

  always_ff @(posedge clk) begin
    if (rst_i)
      state_q <= rv_core_pkg::IDLE;
    else
      state_q <= state_d;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      rv_core_pkg::IDLE: begin
        if (instr_valid_i)
          state_d = rv_core_pkg::DECODE;
      end
      rv_core_pkg::DECODE:    state_d = rv_core_pkg::EXECUTE;
      rv_core_pkg::EXECUTE:   state_d = rv_core_pkg::WRITEBACK;
      rv_core_pkg::WRITEBACK: state_d = halt_i ? rv_core_pkg::HALTED : rv_core_pkg::IDLE;
      // Only reset leaves here
      rv_core_pkg::HALTED:    state_d = rv_core_pkg::HALTED;
      default:                state_d = rv_core_pkg::IDLE;
    endcase
  end

  assign load_ir_o = (state_q == rv_core_pkg::IDLE) && instr_valid_i;
  assign dec_en_o  = (state_q == rv_core_pkg::DECODE);
  assign ex_en_o   = (state_q == rv_core_pkg::EXECUTE);
  assign commit_o  = (state_q == rv_core_pkg::WRITEBACK);
  assign busy_o    = (state_q != rv_core_pkg::IDLE);
  assign halted_o  = (state_q == rv_core_pkg::HALTED);

  // Every commit closes a full accept, decode, execute sequence
  a_commit_seq: assert property (@(posedge clk) disable iff (rst_i)
    commit_o |-> ($past(ex_en_o) && $past(dec_en_o, 2) && $past(load_ir_o, 3)));

endmodule

//--- verilog/rv_core_top.sv
// Core top level with instruction, decode and result registers and output registers
`timescale 1ns/1ps

module rv_core_top #(
  parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               instr_valid_i,
  input  rv_core_pkg::word_t instr_i,
  output logic               busy_o,
  output logic               done_o,
  output rv_core_pkg::wb_t   wb_o,
  output rv_core_pkg::word_t pc_o,
  output rv_core_pkg::word_t instret_o,
  output logic               illegal_o,
  output logic               halt_o
);

  rv_core_pkg::word_t   ir_q;
  rv_core_pkg::decode_t dec_d;
  rv_core_pkg::decode_t dec_q;
  rv_core_pkg::word_t   rs1_val;
  rv_core_pkg::word_t   rs2_val;
  rv_core_pkg::word_t   alu_result;
  rv_core_pkg::word_t   alu_next_pc;
  rv_core_pkg::word_t   result_q;
  rv_core_pkg::word_t   next_pc_q;
  rv_core_pkg::wb_t     wb_q;
  logic                 load_ir;
  logic                 dec_en;
  logic                 ex_en;
  logic                 commit;
  logic                 rf_we;
  logic                 done_q;
  logic                 illegal_q;

  exec_fsm i_exec_fsm (
    .clk           (clk),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .halt_i        (dec_q.halt),
    .load_ir_o     (load_ir),
    .dec_en_o      (dec_en),
    .ex_en_o       (ex_en),
    .commit_o      (commit),
    .busy_o        (busy_o),
    .halted_o      (halt_o)
  );

  control_unit i_control_unit (
    .instr_i (ir_q),
    .dec_o   (dec_d)
  );

  // Pipeline-style holding registers, one stage per FSM state
  always_ff @(posedge clk) begin
    if (load_ir)
      ir_q <= instr_i;
    if (dec_en)
      dec_q <= dec_d;
    if (ex_en) begin
      result_q  <= alu_result;
      next_pc_q <= alu_next_pc;
    end
  end

  assign rf_we = commit && dec_q.wen;

  reg_file i_reg_file (
    .clk      (clk),
    .rst_i    (rst_i),
    .rs1_i    (dec_q.rs1),
    .rs2_i    (dec_q.rs2),
    .rd_i     (dec_q.rd),
    .we_i     (rf_we),
    .wdata_i  (result_q),
    .rdata1_o (rs1_val),
    .rdata2_o (rs2_val)
  );

  alu i_alu (
    .dec_i     (dec_q),
    .rs1_val_i (rs1_val),
    .rs2_val_i (rs2_val),
    .pc_i      (pc_o),
    .result_o  (alu_result),
    .next_pc_o (alu_next_pc)
  );

  pc_counter #(
    .RESET_PC (RESET_PC)
  ) i_pc_counter (
    .clk       (clk),
    .rst_i     (rst_i),
    .commit_i  (commit),
    .next_pc_i (next_pc_q),
    .pc_o      (pc_o),
    .instret_o (instret_o)
  );

  // Retirement report, one cycle after write-back
  always_ff @(posedge clk) begin
    if (rst_i) begin
      done_q    <= 1'b0;
      illegal_q <= 1'b0;
      wb_q      <= '0;
    end else begin
      done_q     <= commit;
      illegal_q  <= commit && dec_q.illegal;
      wb_q.valid <= rf_we && (dec_q.rd != '0);
      if (commit) begin
        wb_q.rd   <= dec_q.rd;
        wb_q.data <= result_q;
      end
    end
  end

  assign done_o    = done_q;
  assign illegal_o = illegal_q;
  assign wb_o      = wb_q;

endmodule

//--- verif/rv_core_checker.sv
// RV32I reference model and output comparison for the core testbench
`timescale 1ns/1ps

module rv_core_checker #(
  parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               instr_valid_i,
  input  rv_core_pkg::word_t instr_i,
  input  logic               busy_i,
  input  logic               done_i,
  input  rv_core_pkg::wb_t   wb_i,
  input  rv_core_pkg::word_t pc_i,
  input  rv_core_pkg::word_t instret_i,
  input  logic               illegal_i,
  input  logic               halt_i,
  output int                 errors_o,
  output int                 checks_o,
  output int                 retired_o
);

  localparam int LATENCY = 3;

  rv_core_pkg::word_t regs [32];
  rv_core_pkg::word_t pc_m;
  rv_core_pkg::word_t instret_m;
  rv_core_pkg::wb_t   exp_wb;
  rv_core_pkg::word_t exp_pc;
  logic               exp_illegal;
  logic               exp_halt;
  logic               pending;
  logic               halted_m;
  int                 cycle_no;
  int                 accept_cycle;

  // Integer ALU group selected by funct3
  function automatic rv_core_pkg::word_t alu_calc(input logic [2:0] f3, input logic alt,
                                                  input rv_core_pkg::word_t x,
                                                  input rv_core_pkg::word_t y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011:  return (x < y) ? 32'd1 : 32'd0;
      3'b100:  return x ^ y;
      3'b101: begin
        if (alt)
          return $signed(x) >>> y[4:0];
        else
          return x >> y[4:0];
      end
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input rv_core_pkg::word_t x,
                                        input rv_core_pkg::word_t y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      3'b111:  return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  task automatic compare_word(input string name, input rv_core_pkg::word_t exp_v,
                              input rv_core_pkg::word_t act_v);
    checks_o++;
    if (act_v != exp_v) begin
      errors_o++;
      $display("ERROR at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic report_failure(input string what);
    errors_o++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  // Executes one instruction on the architectural state
  task automatic run_model(input rv_core_pkg::word_t ins);
    logic [6:0]            op;
    logic [2:0]            f3;
    logic [6:0]            f7;
    rv_core_pkg::reg_idx_t rd;
    rv_core_pkg::word_t    a;
    rv_core_pkg::word_t    b;
    rv_core_pkg::word_t    imm_i;
    rv_core_pkg::word_t    imm_b;
    rv_core_pkg::word_t    imm_u;
    rv_core_pkg::word_t    imm_j;
    rv_core_pkg::word_t    res;
    rv_core_pkg::word_t    npc;
    logic                  wr;
    logic                  ill;
    op    = ins[6:0];
    f3    = ins[14:12];
    f7    = ins[31:25];
    rd    = ins[11:7];
    a     = regs[ins[19:15]];
    b     = regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'h000};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    res   = '0;
    npc   = pc_m + 32'd4;
    wr    = 1'b0;
    ill   = 1'b0;
    case (op)
      rv_core_pkg::LUI: begin
        res = imm_u;
        wr  = 1'b1;
      end
      rv_core_pkg::AUIPC: begin
        res = pc_m + imm_u;
        wr  = 1'b1;
      end
      rv_core_pkg::JAL: begin
        res = pc_m + 32'd4;
        npc = pc_m + imm_j;
        wr  = 1'b1;
      end
      rv_core_pkg::JALR: begin
        res = pc_m + 32'd4;
        npc = (a + imm_i) & ~32'd1;
        wr  = 1'b1;
      end
      rv_core_pkg::BRANCH: begin
        if (branch_taken(f3, a, b))
          npc = pc_m + imm_b;
      end
      rv_core_pkg::IMMED: begin
        res = alu_calc(f3, ins[30] && (f3 == 3'b101), a, imm_i);
        wr  = 1'b1;
      end
      rv_core_pkg::REGREG: begin
        if ((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)))) begin
          res = alu_calc(f3, ins[30], a, b);
          wr  = 1'b1;
        end else begin
          ill = 1'b1;
        end
      end
      default: ill = 1'b1;
    endcase
    // x0 ignores writes
    if (wr && (rd != 5'd0))
      regs[rd] = res;
    exp_wb.valid = wr && (rd != 5'd0);
    exp_wb.rd    = rd;
    exp_wb.data  = res;
    exp_pc       = npc;
    exp_illegal  = ill;
    exp_halt     = (op == rv_core_pkg::JAL) && (rd == 5'd0) && (imm_j == 32'd0);
    pc_m         = npc;
    instret_m    = instret_m + 32'd1;
  endtask

  always @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
      end
      pc_m      = RESET_PC;
      instret_m = '0;
      pending   = 1'b0;
      halted_m  = 1'b0;
      cycle_no  = 0;
      errors_o  = 0;
      checks_o  = 0;
      retired_o = 0;
    end else begin
      cycle_no++;
      if (done_i) begin
        if (!pending) begin
          report_failure("done_o pulsed with no instruction in flight");
        end else begin
          // Driven by the third edge after accept, seen here at the fourth
          if ((cycle_no - accept_cycle) != (LATENCY + 1))
            report_failure($sformatf("done_o came %0d cycles after accept, not %0d",
                                     cycle_no - accept_cycle - 1, LATENCY));
          compare_word("wb_o.valid", {31'b0, exp_wb.valid}, {31'b0, wb_i.valid});
          if (exp_wb.valid) begin
            compare_word("wb_o.rd", {27'b0, exp_wb.rd}, {27'b0, wb_i.rd});
            compare_word("wb_o.data", exp_wb.data, wb_i.data);
          end
          compare_word("pc_o", exp_pc, pc_i);
          compare_word("instret_o", instret_m, instret_i);
          compare_word("illegal_o", {31'b0, exp_illegal}, {31'b0, illegal_i});
          compare_word("halt_o", {31'b0, exp_halt}, {31'b0, halt_i});
          pending  = 1'b0;
          halted_m = exp_halt;
          retired_o++;
        end
      end else if (halted_m) begin
        if (!halt_i || !busy_i)
          report_failure("core left the halted state without a reset");
        if ((pc_i != pc_m) || (instret_i != instret_m))
          report_failure("pc_o or instret_o changed while halted");
      end
      if (instr_valid_i && !busy_i) begin
        if (pending || halted_m)
          report_failure("instruction accepted while busy or halted");
        run_model(instr_i);
        pending      = 1'b1;
        accept_cycle = cycle_no;
      end
    end
  end

endmodule

//--- verif/tb_rv_core.sv
// Testbench top with clock, reset, seeded random RV32I stimulus, timeout, DUT and checker
`timescale 1ns/1ps

module tb_rv_core;

  localparam rv_core_pkg::word_t RESET_PC = 32'h0000_0000;
  localparam int NUM_SEED       = 62;
  localparam int NUM_RANDOM     = 400;
  localparam int NUM_INSTR      = NUM_SEED + NUM_RANDOM + 1;
  localparam int TIMEOUT_CYCLES = 12 * NUM_INSTR + 100;

  logic               clk;
  logic               rst_i;
  logic               instr_valid_i;
  rv_core_pkg::word_t instr_i;
  logic               busy_o;
  logic               done_o;
  rv_core_pkg::wb_t   wb_o;
  rv_core_pkg::word_t pc_o;
  rv_core_pkg::word_t instret_o;
  logic               illegal_o;
  logic               halt_o;
  integer             seed;
  int                 cycle_cnt = 0;
  int                 tb_errors = 0;
  int                 chk_errors;
  int                 chk_checks;
  int                 retired;

  rv_core_top #(
    .RESET_PC (RESET_PC)
  ) i_rv_core_top (
    .clk           (clk),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .wb_o          (wb_o),
    .pc_o          (pc_o),
    .instret_o     (instret_o),
    .illegal_o     (illegal_o),
    .halt_o        (halt_o)
  );

  rv_core_checker #(
    .RESET_PC (RESET_PC)
  ) i_rv_core_checker (
    .clk           (clk),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .busy_i        (busy_o),
    .done_i        (done_o),
    .wb_i          (wb_o),
    .pc_i          (pc_o),
    .instret_i     (instret_o),
    .illegal_i     (illegal_o),
    .halt_i        (halt_o),
    .errors_o      (chk_errors),
    .checks_o      (chk_checks),
    .retired_o     (retired)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic rv_core_pkg::word_t rand32();
    return $random(seed);
  endfunction

  // One random instruction from the supported classes, some illegal
  function automatic rv_core_pkg::word_t gen_instr();
    rv_core_pkg::word_t    r;
    rv_core_pkg::word_t    imm;
    rv_core_pkg::word_t    w;
    rv_core_pkg::reg_idx_t rd;
    rv_core_pkg::reg_idx_t rs1;
    rv_core_pkg::reg_idx_t rs2;
    logic [2:0]            f3;
    logic [6:0]            f7;
    logic [6:0]            bad_op;
    logic                  flip;
    r    = rand32();
    imm  = rand32();
    rd   = r[8:4];
    rs1  = r[13:9];
    rs2  = r[18:14];
    f3   = r[21:19];
    flip = r[22];
    f7   = (flip && ((f3 == 3'b000) || (f3 == 3'b101))) ? 7'h20 : 7'h00;
    case (r[3:0])
      4'd0, 4'd1, 4'd2, 4'd3: w = {f7, rs2, rs1, f3, rd, rv_core_pkg::REGREG};
      4'd4, 4'd5, 4'd6, 4'd15: begin
        // Shift immediates need a legal funct7 field
        if (f3 == 3'b001)
          imm[31:25] = 7'h00;
        else if (f3 == 3'b101)
          imm[31:25] = {1'b0, flip, 5'b0};
        w = {imm[31:20], rs1, f3, rd, rv_core_pkg::IMMED};
      end
      4'd7:  w = {imm[31:12], rd, rv_core_pkg::LUI};
      4'd8:  w = {imm[31:12], rd, rv_core_pkg::AUIPC};
      4'd9:  w = {imm[31:12], rd, rv_core_pkg::JAL};
      4'd10: w = {imm[31:20], rs1, 3'b000, rd, rv_core_pkg::JALR};
      4'd11, 4'd12: begin
        // funct3 010 and 011 are not branches
        if (f3[2:1] == 2'b01)
          f3[2] = 1'b1;
        if (flip)
          rs2 = rs1;
        w = {imm[31:25], rs2, rs1, f3, imm[11:7], rv_core_pkg::BRANCH};
      end
      4'd13: begin
        case (r[25:23])
          3'd0:    bad_op = rv_core_pkg::LOAD;
          3'd1:    bad_op = rv_core_pkg::STORE;
          3'd2:    bad_op = rv_core_pkg::SYSTEM;
          3'd3:    bad_op = rv_core_pkg::MISCMEM;
          default: bad_op = 7'h7f;
        endcase
        w = {imm[31:7], bad_op};
      end
      default: w = {7'h01, rs2, rs1, f3, rd, rv_core_pkg::REGREG};
    endcase
    // Keep the halt word out of the random stream
    if (w == {20'h0, 5'd0, rv_core_pkg::JAL})
      w[11:7] = 5'd1;
    return w;
  endfunction

  // Called on a falling edge, waits for the core to be free
  task automatic send_instr(input rv_core_pkg::word_t w);
    while (busy_o)
      @(negedge clk);
    instr_valid_i = 1'b1;
    instr_i       = w;
    @(negedge clk);
    instr_valid_i = 1'b0;
  endtask

  task automatic report_and_finish();
    $display("Summary: %0d checks, %0d checker errors, %0d testbench errors",
             chk_checks, chk_errors, tb_errors);
    if ((chk_errors == 0) && (tb_errors == 0))
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  endtask

  initial begin
    rv_core_pkg::word_t val;
    seed          = 32'h8bd9552e;
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    repeat (4) @(negedge clk);
    rst_i = 1'b0;
    // Load every register with a random value
    for (int r = 1; r < 32; r++) begin
      val = rand32();
      send_instr({val[31:12], 5'(r), rv_core_pkg::LUI});
      send_instr({val[11:0], 5'(r), 3'b000, 5'(r), rv_core_pkg::IMMED});
    end
    repeat (NUM_RANDOM) send_instr(gen_instr());
    send_instr({20'h0, 5'd0, rv_core_pkg::JAL});
    while (!halt_o)
      @(negedge clk);
    // Strobes after halt must be ignored
    repeat (4) begin
      instr_valid_i = 1'b1;
      instr_i       = gen_instr();
      @(negedge clk);
      instr_valid_i = 1'b0;
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
    if (retired != NUM_INSTR) begin
      $display("Retired %0d instructions, expected %0d", retired, NUM_INSTR);
      tb_errors++;
    end
    report_and_finish();
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    tb_errors++;
    report_and_finish();
  end

endmodule

//--- filelist.f
verilog/rv_core_pkg.sv
verilog/control_unit.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/pc_counter.sv
verilog/exec_fsm.sv
verilog/rv_core_top.sv
verif/rv_core_checker.sv
verif/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Compile and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_rv_core -f filelist.f -o sim_rv_core
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  exit 0
fi
exit 1
